// ==== src/stack_settings.svh ====
`ifndef STACK_SETTINGS_SVH
`define STACK_SETTINGS_SVH

// Status stack.
`define STS_WIDTH 25
`define STS_DEPTH 7

// Subroutine and interrupt return addresses.
`define PC_WIDTH 14
`define PC_DEPTH 16

// Loop stack entries hold an end address and a count.
`define LOOP_DEPTH 4
`define CNT_WIDTH 14

`endif

// ==== src/seqTypesPkg.sv ====
`default_nettype none

`include "stack_settings.svh"

package seqTypesPkg;

  // Saved arithmetic, mode and mask status.
  typedef logic [`STS_WIDTH-1:0] statusWord;

  typedef logic [`PC_WIDTH-1:0] pcAddr;    // Program address.

  typedef logic [`CNT_WIDTH-1:0] loopCount;    // Iterations left.

  // End address in the upper part, count in the lower part.
  typedef logic [`PC_WIDTH+`CNT_WIDTH-1:0] loopEntry;

endpackage

`default_nettype wire

// ==== src/seqCmdPkg.sv ====
`default_nettype none

package seqCmdPkg;

  typedef enum logic [2:0] {
    opNop       = 3'd0,
    opCall      = 3'd1,
    opReturn    = 3'd2,
    opIntEnter  = 3'd3,    // Saves PC and status together.
    opIntReturn = 3'd4,
    opLoopStart = 3'd5,
    opLoopEnd   = 3'd6
  } cmdOp;

  typedef enum logic {
    ctrlRun   = 1'b0,
    ctrlError = 1'b1    // Waits for clrErr.
  } ctrlState;

endpackage

`default_nettype wire

// ==== src/lifoStack.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stack_settings.svh"

module lifoStack #(
  parameter int WIDTH = `STS_WIDTH,
  parameter int DEPTH = `STS_DEPTH
) (
  input  wire logic             STSCLK,
  input  wire logic             T_RST,
  input  wire logic             push,
  input  wire logic             pop,
  input  wire logic [WIDTH-1:0] din,
  output logic      [WIDTH-1:0] top,
  output logic                  full,
  output logic                  empty,
  output logic                  has1
);

  // One spare pointer code so that all ones never collides with a full stack.
  localparam int PTR_WIDTH  = $clog2(DEPTH + 1);
  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  localparam logic [PTR_WIDTH-1:0] PTR_EMPTY = '1;
  localparam logic [PTR_WIDTH-1:0] PTR_FULL  = PTR_WIDTH'(DEPTH - 1);
  localparam logic [PTR_WIDTH-1:0] PTR_ONE   = '0;

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] ptr;
  logic [PTR_WIDTH-1:0] ptrInc;
  logic [PTR_WIDTH-1:0] ptrDec;

  assign ptrInc = ptr + 1'b1;    // Wraps from empty to slot zero.
  assign ptrDec = ptr - 1'b1;

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= PTR_EMPTY;
    end else if (push) begin    // Push wins over pop.
      ptr <= ptrInc;
    end else if (pop) begin
      ptr <= ptrDec;
    end
  end

  always_ff @(posedge STSCLK) begin
    if (push) begin
      mem[ptrInc[ADDR_WIDTH-1:0]] <= din;
    end
  end

  assign empty = (ptr == PTR_EMPTY);
  assign full  = (ptr == PTR_FULL);
  assign has1  = (ptr == PTR_ONE);

  // An empty stack shows zero on top.
  assign top = empty ? '0 : mem[ptr[ADDR_WIDTH-1:0]];

endmodule

`default_nettype wire

// ==== src/stackControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module stackControl
  import seqTypesPkg::*;
  import seqCmdPkg::*;
(
  input  wire logic            STSCLK,
  input  wire logic            T_RST,

  input  wire logic            cmdValid,
  input  wire seqCmdPkg::cmdOp cmdOp,
  input  wire pcAddr           cmdPc,
  input  wire statusWord       cmdStatus,
  input  wire loopCount        cmdCount,
  output logic                 cmdReady,

  input  wire logic            clrErr,
  output logic                 errFlag,

  input  wire logic            pcFull,
  input  wire logic            pcEmpty,
  input  wire logic            stsFull,
  input  wire logic            stsEmpty,
  input  wire logic            loopFull,
  input  wire logic            loopEmpty,

  output logic                 pcPush,
  output logic                 pcPop,
  output pcAddr                pcDin,
  output logic                 stsPush,
  output logic                 stsPop,
  output statusWord            stsDin,
  output logic                 loopPush,
  output logic                 loopPop,
  output loopEntry             loopDin
);

  ctrlState state;
  ctrlState stateNext;

  logic accept;
  logic legal;
  logic commit;

  logic pcPushReq;
  logic pcPopReq;
  logic stsPushReq;
  logic stsPopReq;
  logic loopPushReq;
  logic loopPopReq;

  assign cmdReady = (state == ctrlRun);
  assign errFlag  = (state == ctrlError);
  assign accept   = cmdValid && cmdReady;

  // Which stacks the command touches.
  always_comb begin
    pcPushReq   = 1'b0;
    pcPopReq    = 1'b0;
    stsPushReq  = 1'b0;
    stsPopReq   = 1'b0;
    loopPushReq = 1'b0;
    loopPopReq  = 1'b0;
    case (cmdOp)
      opCall:      pcPushReq = 1'b1;
      opReturn:    pcPopReq  = 1'b1;
      opIntEnter: begin
        pcPushReq  = 1'b1;
        stsPushReq = 1'b1;
      end
      opIntReturn: begin
        pcPopReq  = 1'b1;
        stsPopReq = 1'b1;
      end
      opLoopStart: loopPushReq = 1'b1;
      opLoopEnd:   loopPopReq  = 1'b1;
      default: ;    // Nop and unused codes.
    endcase
  end

  // Every stack the command needs must have room or an entry.
  assign legal = !(pcPushReq   && pcFull)   && !(pcPopReq   && pcEmpty)  &&
                 !(stsPushReq  && stsFull)  && !(stsPopReq  && stsEmpty) &&
                 !(loopPushReq && loopFull) && !(loopPopReq && loopEmpty);

  assign commit = accept && legal;

  assign pcPush   = commit && pcPushReq;
  assign pcPop    = commit && pcPopReq;
  assign stsPush  = commit && stsPushReq;
  assign stsPop   = commit && stsPopReq;
  assign loopPush = commit && loopPushReq;
  assign loopPop  = commit && loopPopReq;

  assign pcDin   = cmdPc;
  assign stsDin  = cmdStatus;
  assign loopDin = {cmdPc, cmdCount};    // End address on top.

  always_comb begin
    stateNext = state;
    case (state)
      ctrlRun: begin
        if (accept && !legal) begin
          stateNext = ctrlError;    // Command is dropped whole.
        end
      end
      ctrlError: begin
        if (clrErr) begin
          stateNext = ctrlRun;
        end
      end
      default: stateNext = ctrlRun;
    endcase
  end

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      state <= ctrlRun;
    end else begin
      state <= stateNext;
    end
  end

endmodule

`default_nettype wire

// ==== src/seqStacks.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stack_settings.svh"

module seqStacks
  import seqTypesPkg::*;
  import seqCmdPkg::*;
(
  input  wire logic            STSCLK,
  input  wire logic            T_RST,

  input  wire logic            cmdValid,
  input  wire seqCmdPkg::cmdOp cmdOp,
  input  wire pcAddr           cmdPc,
  input  wire statusWord       cmdStatus,
  input  wire loopCount        cmdCount,
  output logic                 cmdReady,
  input  wire logic            clrErr,
  output logic                 errFlag,

  output pcAddr                pcTop,
  output logic                 pcEmpty,
  output logic                 pcFull,

  output statusWord            stsTop,
  output logic                 stsEmpty,
  output logic                 stsFull,
  output logic                 stsHas1,

  output loopEntry             loopTop,
  output logic                 loopEmpty,
  output logic                 loopFull
);

  logic      pcPush;
  logic      pcPop;
  pcAddr     pcDin;
  logic      stsPush;
  logic      stsPop;
  statusWord stsDin;
  logic      loopPush;
  logic      loopPop;
  loopEntry  loopDin;

  stackControl ctrl (
    .STSCLK    (STSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmdOp     (cmdOp),
    .cmdPc     (cmdPc),
    .cmdStatus (cmdStatus),
    .cmdCount  (cmdCount),
    .cmdReady  (cmdReady),
    .clrErr    (clrErr),
    .errFlag   (errFlag),
    .pcFull    (pcFull),
    .pcEmpty   (pcEmpty),
    .stsFull   (stsFull),
    .stsEmpty  (stsEmpty),
    .loopFull  (loopFull),
    .loopEmpty (loopEmpty),
    .pcPush    (pcPush),
    .pcPop     (pcPop),
    .pcDin     (pcDin),
    .stsPush   (stsPush),
    .stsPop    (stsPop),
    .stsDin    (stsDin),
    .loopPush  (loopPush),
    .loopPop   (loopPop),
    .loopDin   (loopDin)
  );

  lifoStack #(.WIDTH($bits(pcAddr)), .DEPTH(`PC_DEPTH)) pcStk (
    .STSCLK (STSCLK),
    .T_RST  (T_RST),
    .push   (pcPush),
    .pop    (pcPop),
    .din    (pcDin),
    .top    (pcTop),
    .full   (pcFull),
    .empty  (pcEmpty),
    .has1   ()
  );

  lifoStack #(.WIDTH($bits(statusWord)), .DEPTH(`STS_DEPTH)) stsStk (
    .STSCLK (STSCLK),
    .T_RST  (T_RST),
    .push   (stsPush),
    .pop    (stsPop),
    .din    (stsDin),
    .top    (stsTop),
    .full   (stsFull),
    .empty  (stsEmpty),
    .has1   (stsHas1)
  );

  // The sequencer does the loop counting.
  lifoStack #(.WIDTH($bits(loopEntry)), .DEPTH(`LOOP_DEPTH)) loopStk (
    .STSCLK (STSCLK),
    .T_RST  (T_RST),
    .push   (loopPush),
    .pop    (loopPop),
    .din    (loopDin),
    .top    (loopTop),
    .full   (loopFull),
    .empty  (loopEmpty),
    .has1   ()
  );

endmodule

`default_nettype wire

// ==== test/seqStacks_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module seqStacks_assert (
  input wire logic STSCLK,
  input wire logic T_RST,
  input wire logic cmdReady,
  input wire logic errFlag,
  input wire logic clrErr,
  input wire logic pcPush,
  input wire logic pcPop,
  input wire logic stsPush,
  input wire logic stsPop,
  input wire logic loopPush,
  input wire logic loopPop,
  input wire logic pcFull,
  input wire logic pcEmpty,
  input wire logic stsFull,
  input wire logic stsEmpty,
  input wire logic loopFull,
  input wire logic loopEmpty
);

  int failCount = 0;    // Read by the testbench after every step.

  // Commands stay held off until the error is cleared.
  readyOutsideError: assert property (@(posedge STSCLK) disable iff (T_RST)
    errFlag && !clrErr |=> errFlag && !cmdReady)
    else begin
      failCount++;
      $error("cmdReady rose or errFlag fell without clrErr");
    end

  // The controller never asks one stack to push and pop at once.
  singleStrobe: assert property (@(posedge STSCLK) disable iff (T_RST)
    !(pcPush && pcPop) && !(stsPush && stsPop) && !(loopPush && loopPop))
    else begin
      failCount++;
      $error("A stack got push and pop in the same cycle");
    end

  guardedAccess: assert property (@(posedge STSCLK) disable iff (T_RST)
    !(pcPush && pcFull) && !(stsPush && stsFull) && !(loopPush && loopFull) &&
    !(pcPop && pcEmpty) && !(stsPop && stsEmpty) && !(loopPop && loopEmpty))
    else begin
      failCount++;
      $error("A push reached a full stack or a pop reached an empty one");
    end

endmodule

bind stackControl seqStacks_assert chkAsrt (
  .STSCLK    (STSCLK),
  .T_RST     (T_RST),
  .cmdReady  (cmdReady),
  .errFlag   (errFlag),
  .clrErr    (clrErr),
  .pcPush    (pcPush),
  .pcPop     (pcPop),
  .stsPush   (stsPush),
  .stsPop    (stsPop),
  .loopPush  (loopPush),
  .loopPop   (loopPop),
  .pcFull    (pcFull),
  .pcEmpty   (pcEmpty),
  .stsFull   (stsFull),
  .stsEmpty  (stsEmpty),
  .loopFull  (loopFull),
  .loopEmpty (loopEmpty)
);

`default_nettype wire

// ==== test/seqStacks_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module seqStacks_tb
  import seqTypesPkg::*;
  import seqCmdPkg::*;
();

  localparam int    RESET_CYCLES = 5;
  localparam string DATA_FILE    = "test/seqStacks_testdata.txt";

  typedef struct {
    string      name;
    bit         valid;
    int         op;
    pcAddr      pc;
    statusWord  status;
    loopCount   count;
    bit         clr;
    pcAddr      expPc;
    statusWord  expSts;
    loopEntry   expLoop;
    logic [6:0] expFlags;    // pcE pcF stsE stsF stsHas1 loopE loopF.
    bit         expErr;
  } stepRec;

  logic      STSCLK;
  logic      T_RST;
  logic      cmdValid;
  cmdOp      opCode;
  pcAddr     cmdPc;
  statusWord cmdStatus;
  loopCount  cmdCount;
  logic      clrErr;

  logic      cmdReady;
  logic      errFlag;
  pcAddr     pcTop;
  logic      pcEmpty;
  logic      pcFull;
  statusWord stsTop;
  logic      stsEmpty;
  logic      stsFull;
  logic      stsHas1;
  loopEntry  loopTop;
  logic      loopEmpty;
  logic      loopFull;

  stepRec steps[$];
  int     cycleCount = 0;
  int     cycleLimit = 0;

  seqStacks UUT (
    .STSCLK    (STSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmdOp     (opCode),
    .cmdPc     (cmdPc),
    .cmdStatus (cmdStatus),
    .cmdCount  (cmdCount),
    .cmdReady  (cmdReady),
    .clrErr    (clrErr),
    .errFlag   (errFlag),
    .pcTop     (pcTop),
    .pcEmpty   (pcEmpty),
    .pcFull    (pcFull),
    .stsTop    (stsTop),
    .stsEmpty  (stsEmpty),
    .stsFull   (stsFull),
    .stsHas1   (stsHas1),
    .loopTop   (loopTop),
    .loopEmpty (loopEmpty),
    .loopFull  (loopFull)
  );

  always #2 STSCLK = ~STSCLK;

  always @(posedge STSCLK) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin    // A handshake never completed.
      $display("Simulation timed out before all test lines were applied");
      $display("Finished with errors");
      $fatal(1, "Cycle limit of %0d reached", cycleLimit);
    end
  end

  task automatic checkVal(input string testName, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", testName, what, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Mismatch in step %s", testName);
    end
  endtask

  task automatic loadSteps();
    int          fd;
    int          n;
    string       line;
    stepRec      rec;
    string       nameTmp;
    int          validTmp;
    int          opTmp;
    int          clrTmp;
    int          errTmp;
    logic [31:0] pcTmp;
    logic [31:0] stsTmp;
    logic [31:0] cntTmp;
    logic [31:0] expPcTmp;
    logic [31:0] expStsTmp;
    logic [31:0] expLoopTmp;
    logic [6:0]  flagTmp;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the test data file %s", DATA_FILE);
      $display("Finished with errors");
      $fatal(1, "No stimulus available");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() == 0 || line.getc(0) == "#") continue;    // Column notes.
        n = $sscanf(line, "%s %d %d %h %h %h %d %h %h %h %b %d", nameTmp, validTmp,
                    opTmp, pcTmp, stsTmp, cntTmp, clrTmp, expPcTmp, expStsTmp,
                    expLoopTmp, flagTmp, errTmp);
        if (n <= 0) continue;
        if (n != 12) begin
          $display("Malformed line in the test data file: %s", line);
          $display("Finished with errors");
          $fatal(1, "Bad stimulus line");
        end else begin
          rec.name     = nameTmp;
          rec.valid    = validTmp[0];
          rec.op       = opTmp;
          rec.pc       = pcAddr'(pcTmp);
          rec.status   = statusWord'(stsTmp);
          rec.count    = loopCount'(cntTmp);
          rec.clr      = clrTmp[0];
          rec.expPc    = pcAddr'(expPcTmp);
          rec.expSts   = statusWord'(expStsTmp);
          rec.expLoop  = loopEntry'(expLoopTmp);
          rec.expFlags = flagTmp;
          rec.expErr   = errTmp[0];
          steps.push_back(rec);
        end
      end
      $fclose(fd);
    end
  endtask

  // Drives one line and returns on the falling edge after it took effect.
  task automatic applyStep(input stepRec s);
    bit pending;
    bit readySeen;
    cmdValid  = s.valid;
    opCode    = cmdOp'(s.op[2:0]);
    cmdPc     = s.pc;
    cmdStatus = s.status;
    cmdCount  = s.count;
    clrErr    = s.clr;
    pending   = s.valid;
    do begin
      readySeen = cmdReady;
      @(posedge STSCLK);
      if (readySeen) pending = 1'b0;
      @(negedge STSCLK);
      clrErr = 1'b0;    // Sampled once.
    end while (pending);
    cmdValid = 1'b0;
    opCode   = opNop;
  endtask

  task automatic checkStep(input stepRec s);
    checkVal(s.name, "pcTop", s.expPc, pcTop);
    checkVal(s.name, "stsTop", s.expSts, stsTop);
    checkVal(s.name, "loopTop", s.expLoop, loopTop);
    checkVal(s.name, "flags", s.expFlags,
             {pcEmpty, pcFull, stsEmpty, stsFull, stsHas1, loopEmpty, loopFull});
    checkVal(s.name, "errFlag", s.expErr, errFlag);
    checkVal(s.name, "cmdReady", !s.expErr, cmdReady);
    if (UUT.ctrl.chkAsrt.failCount != 0) begin
      $display("An assertion failed during step %s", s.name);
      $display("Finished with errors");
      $fatal(1, "Assertion failure");
    end
  endtask

  initial begin
    STSCLK    = 1'b0;
    T_RST     = 1'b1;
    cmdValid  = 1'b0;
    opCode    = opNop;
    cmdPc     = '0;
    cmdStatus = '0;
    cmdCount  = '0;
    clrErr    = 1'b0;
    loadSteps();
    cycleLimit = 10 * steps.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge STSCLK);
    @(negedge STSCLK);
    T_RST = 1'b0;
    foreach (steps[i]) begin
      applyStep(steps[i]);
      checkStep(steps[i]);
    end
    if (steps.size() > 0 && UUT.ctrl.chkAsrt.failCount == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("No test lines ran or an assertion failed");
      $display("Finished with errors");
      $fatal(1, "Run incomplete");
    end
  end

endmodule

`default_nettype wire

// ==== test/seqStacks_testdata.txt ====
# name valid op pc status count clrErr expPcTop expStsTop expLoopTop flags expErr
# op 0..6 = nop call return intEnter intReturn loopStart loopEnd; flags = pcE pcF stsE stsF stsHas1 loopE loopF
reset_state  0 0 0000 0000000 0000 0 0000 0000000 0000000 1010010 0
call_a       1 1 0100 0000000 0000 0 0100 0000000 0000000 0010010 0
call_b       1 1 0200 0000000 0000 0 0200 0000000 0000000 0010010 0
call_c       1 1 0300 0000000 0000 0 0300 0000000 0000000 0010010 0
ret_c        1 2 0000 0000000 0000 0 0200 0000000 0000000 0010010 0
call_d       1 1 0400 0000000 0000 0 0400 0000000 0000000 0010010 0
ret_d        1 2 0000 0000000 0000 0 0200 0000000 0000000 0010010 0
ret_b        1 2 0000 0000000 0000 0 0100 0000000 0000000 0010010 0
ret_a        1 2 0000 0000000 0000 0 0000 0000000 0000000 1010010 0
ret_under    1 2 0000 0000000 0000 0 0000 0000000 0000000 1010010 1
idle_err     0 0 0000 0000000 0000 0 0000 0000000 0000000 1010010 1
clear_under  0 0 0000 0000000 0000 1 0000 0000000 0000000 1010010 0
call_e       1 1 0A5A 0000000 0000 0 0A5A 0000000 0000000 0010010 0
iret_nosts   1 4 0000 0000000 0000 0 0A5A 0000000 0000000 0010010 1
call_wait    1 1 0B00 0000000 0000 1 0B00 0000000 0000000 0010010 0
ret_f        1 2 0000 0000000 0000 0 0A5A 0000000 0000000 0010010 0
ret_e        1 2 0000 0000000 0000 0 0000 0000000 0000000 1010010 0
int_1        1 3 0011 1000001 0000 0 0011 1000001 0000000 0000110 0
int_2        1 3 0022 0AAAAAA 0000 0 0022 0AAAAAA 0000000 0000010 0
int_3        1 3 0033 1555555 0000 0 0033 1555555 0000000 0000010 0
int_4        1 3 0044 0123456 0000 0 0044 0123456 0000000 0000010 0
int_5        1 3 0055 1FEDCBA 0000 0 0055 1FEDCBA 0000000 0000010 0
int_6        1 3 0066 0F0F0F0 0000 0 0066 0F0F0F0 0000000 0000010 0
int_7        1 3 0077 1FFFFFF 0000 0 0077 1FFFFFF 0000000 0001010 0
int_over     1 3 0088 0000088 0000 0 0077 1FFFFFF 0000000 0001010 1
clear_over   0 0 0000 0000000 0000 1 0077 1FFFFFF 0000000 0001010 0
iret_7       1 4 0000 0000000 0000 0 0066 0F0F0F0 0000000 0000010 0
iret_6       1 4 0000 0000000 0000 0 0055 1FEDCBA 0000000 0000010 0
iret_5       1 4 0000 0000000 0000 0 0044 0123456 0000000 0000010 0
iret_4       1 4 0000 0000000 0000 0 0033 1555555 0000000 0000010 0
iret_3       1 4 0000 0000000 0000 0 0022 0AAAAAA 0000000 0000010 0
iret_2       1 4 0000 0000000 0000 0 0011 1000001 0000000 0000110 0
iret_1       1 4 0000 0000000 0000 0 0000 0000000 0000000 1010010 0
loop_1       1 5 0100 0000000 000A 0 0000 0000000 040000A 1010000 0
loop_2       1 5 0200 0000000 0064 0 0000 0000000 0800064 1010000 0
loop_3       1 5 3FFF 0000000 3FFF 0 0000 0000000 FFFFFFF 1010000 0
loop_4       1 5 1234 0000000 0005 0 0000 0000000 48D0005 1010001 0
loop_over    1 5 0500 0000000 0001 0 0000 0000000 48D0005 1010001 1
clear_loop   0 0 0000 0000000 0000 1 0000 0000000 48D0005 1010001 0
lend_4       1 6 0000 0000000 0000 0 0000 0000000 FFFFFFF 1010000 0
lend_3       1 6 0000 0000000 0000 0 0000 0000000 0800064 1010000 0
lend_2       1 6 0000 0000000 0000 0 0000 0000000 040000A 1010000 0
lend_1       1 6 0000 0000000 0000 0 0000 0000000 0000000 1010010 0
lend_under   1 6 0000 0000000 0000 0 0000 0000000 0000000 1010010 1
clear_lend   0 0 0000 0000000 0000 1 0000 0000000 0000000 1010010 0
mix_call     1 1 0123 0000000 0000 0 0123 0000000 0000000 0010010 0
mix_loop     1 5 0040 0000000 0010 0 0123 0000000 0100010 0010000 0
mix_int      1 3 0200 0000ABC 0000 0 0200 0000ABC 0100010 0000100 0
mix_lend     1 6 0000 0000000 0000 0 0200 0000ABC 0000000 0000110 0
mix_ret      1 2 0000 0000000 0000 0 0123 0000ABC 0000000 0000110 0
mix_iret     1 4 0000 0000000 0000 0 0000 0000000 0000000 1010010 0
mix_nop      1 0 0000 0000000 0000 0 0000 0000000 0000000 1010010 0

// ==== vlog.f ====
+incdir+src
src/seqTypesPkg.sv
src/seqCmdPkg.sv
src/lifoStack.sv
src/stackControl.sv
src/seqStacks.sv
test/seqStacks_assert.sv
test/seqStacks_tb.sv
